// ==== design/rob_alloc.sv ====
module rob_alloc #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         alloc_req,
    input  logic                         alloc_is_store,
    input  logic                         alloc_pred_taken,
    input  rob_pkg::reg_name_t           alloc_rd,
    input  logic                         retire,
    input  logic                         flush,
    output logic                         alloc_ok,
    output logic                         full,
    output logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
    rob_alloc_if.src                     alloc
);

    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam logic [TAG_W:0] FULL_CNT = (TAG_W+1)'(ROB_DEPTH);

    logic [TAG_W-1:0] tail;
    logic [TAG_W:0]   count;
    logic [TAG_W:0]   count_next;

    // a grant in the flush cycle would be lost anyway
    assign alloc_ok  = alloc_req && !full && !flush;
    assign alloc_tag = tail;

    assign alloc.we         = alloc_ok;
    assign alloc.tag        = tail;
    assign alloc.rd         = alloc_rd;
    assign alloc.is_store   = alloc_is_store;
    assign alloc.pred_taken = alloc_pred_taken;

    always_comb begin
        case ({alloc_ok, retire})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count; // none, or grant and retire together
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail  <= '0;
            count <= '0;
            full  <= 1'b0;
        end else begin
            if (alloc_ok) tail <= tail + 1'b1; // wraps at ROB_DEPTH
            count <= count_next;
            full  <= (count_next == FULL_CNT);
        end
    end

    count_in_range: assert property (@(posedge clk) disable iff (rst)
        count <= FULL_CNT);

    // commit must only see a head that was granted here
    no_retire_when_empty: assert property (@(posedge clk) disable iff (rst)
        retire |-> count != '0);

endmodule

// ==== design/rob_alloc_if.sv ====
interface rob_alloc_if #(
    parameter int ROB_DEPTH = 16
);
    import rob_pkg::*;

    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic             we;          // one pulse per grant
    logic [TAG_W-1:0] tag;
    reg_name_t        rd;
    logic             is_store;
    logic             pred_taken;

    modport src (output we, tag, rd, is_store, pred_taken);
    modport dst (input we, tag, rd, is_store, pred_taken);

endinterface

// ==== design/rob_commit.sv ====
module rob_commit #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    rob_head_if.commit                   head,
    output logic                         rf_we,
    output rob_pkg::reg_name_t           rf_rd,
    output rob_pkg::data_t               rf_data,
    output logic [$clog2(ROB_DEPTH)-1:0] rf_tag,
    output logic                         store_commit,
    output logic [$clog2(ROB_DEPTH)-1:0] store_tag,
    output logic                         flush,
    output rob_pkg::addr_t               redirect_pc
);
    import rob_pkg::*;

    logic retire_now;
    logic store_now;
    logic flush_now;

    // head finished, retire it this cycle
    assign retire_now = head.valid && head.done;
    assign store_now  = head.is_store == STORE;
    assign flush_now  = retire_now && head.mispredict;

    assign head.retire = retire_now;
    assign head.flush  = flush_now;

    always_ff @(posedge clk) begin
        if (rst) begin
            rf_we        <= 1'b0;
            store_commit <= 1'b0;
            flush        <= 1'b0;
        end else begin
            rf_we        <= retire_now && !store_now;
            store_commit <= retire_now && store_now;
            flush        <= flush_now;
        end
    end

    always_ff @(posedge clk) begin
        if (retire_now) begin
            rf_rd     <= head.rd;
            rf_data   <= head.data;
            rf_tag    <= head.tag;
            store_tag <= head.tag;
        end
        if (flush_now) redirect_pc <= head.target; // held until next mispredict
    end

    one_commit_kind: assert property (@(posedge clk) disable iff (rst)
        !(rf_we && store_commit));

endmodule

// ==== design/rob_head_if.sv ====
interface rob_head_if #(
    parameter int ROB_DEPTH = 16
);
    import rob_pkg::*;

    localparam int TAG_W = $clog2(ROB_DEPTH);

    // head entry, from the table
    logic             valid;
    logic             done;
    logic [TAG_W-1:0] tag;
    reg_name_t        rd;
    data_t            data;
    logic             is_store;
    logic             mispredict;
    addr_t            target;

    // decision, from commit
    logic             retire;
    logic             flush;

    // "table" is a keyword, hence tbl
    modport tbl (
        output valid, done, tag, rd, data, is_store, mispredict, target,
        input  retire, flush
    );

    modport commit (
        input  valid, done, tag, rd, data, is_store, mispredict, target,
        output retire, flush
    );

endinterface

// ==== design/rob_pkg.sv ====
package rob_pkg;

    localparam int XLEN  = 32;
    localparam int REG_W = 5;

    // architectural register name
    typedef logic [REG_W-1:0] reg_name_t;

    typedef logic [XLEN-1:0] data_t; // result value
    typedef logic [XLEN-1:0] addr_t; // pc or jump target

    // is_store flag, set only for sb/sh/sw
    localparam logic STORE = 1'b1;

    // branch direction before the unit reports back
    localparam logic NOT_TAKEN = 1'b0;

endpackage

// ==== design/rob_table.sv ====
module rob_table #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    rob_alloc_if.dst                     alloc,
    input  logic                         ex_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] ex_tag,
    input  rob_pkg::data_t               ex_data,
    input  logic                         ex_taken,
    input  rob_pkg::addr_t               ex_target,
    rob_head_if.tbl                      head
);
    import rob_pkg::*;

    localparam int TAG_W = $clog2(ROB_DEPTH);

    // per-entry control
    logic [ROB_DEPTH-1:0] valid;
    logic [ROB_DEPTH-1:0] done;

    // per-entry payload
    reg_name_t            rd_q     [ROB_DEPTH];
    data_t                data_q   [ROB_DEPTH];
    addr_t                target_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] store_q;
    logic [ROB_DEPTH-1:0] pred_q;
    logic [ROB_DEPTH-1:0] taken_q;

    logic [TAG_W-1:0] head_ptr;

    always_ff @(posedge clk) begin
        if (rst || head.flush) begin
            valid    <= '0;
            done     <= '0;
            head_ptr <= '0;
        end else begin
            if (head.retire) begin
                valid[head_ptr] <= 1'b0;
                done[head_ptr]  <= 1'b0;
                head_ptr        <= head_ptr + 1'b1;
            end
            if (alloc.we) begin
                valid[alloc.tag] <= 1'b1;
                done[alloc.tag]  <= 1'b0;
            end
            if (ex_valid) done[ex_tag] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc.we) begin
            rd_q[alloc.tag]    <= alloc.rd;
            store_q[alloc.tag] <= alloc.is_store;
            pred_q[alloc.tag]  <= alloc.pred_taken;
            taken_q[alloc.tag] <= NOT_TAKEN; // until the unit reports
        end
        if (ex_valid) begin
            data_q[ex_tag]   <= ex_data;
            taken_q[ex_tag]  <= ex_taken;
            target_q[ex_tag] <= ex_target;
        end
    end

    assign head.valid      = valid[head_ptr];
    assign head.done       = done[head_ptr];
    assign head.tag        = head_ptr;
    assign head.rd         = rd_q[head_ptr];
    assign head.data       = data_q[head_ptr];
    assign head.is_store   = store_q[head_ptr];
    assign head.target     = target_q[head_ptr];
    assign head.mispredict = pred_q[head_ptr] != taken_q[head_ptr];

    // units only report on live, unfinished tags
    ex_names_live_entry: assert property (@(posedge clk) disable iff (rst)
        ex_valid |-> valid[ex_tag] && !done[ex_tag]);

    // tail from the allocator never laps the head
    alloc_no_overwrite: assert property (@(posedge clk) disable iff (rst)
        alloc.we |-> !valid[alloc.tag]);

endmodule

// ==== design/rob_top.sv ====
module rob_top #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    // allocation
    input  logic                         alloc_req,
    input  rob_pkg::reg_name_t           alloc_rd,
    input  logic                         alloc_is_store,
    input  logic                         alloc_pred_taken,
    output logic                         alloc_ok,
    output logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
    output logic                         full,
    // completion
    input  logic                         ex_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] ex_tag,
    input  rob_pkg::data_t               ex_data,
    input  logic                         ex_taken,
    input  rob_pkg::addr_t               ex_target,
    // commit
    output logic                         rf_we,
    output rob_pkg::reg_name_t           rf_rd,
    output rob_pkg::data_t               rf_data,
    output logic [$clog2(ROB_DEPTH)-1:0] rf_tag,
    output logic                         store_commit,
    output logic [$clog2(ROB_DEPTH)-1:0] store_tag,
    output logic                         flush,
    output rob_pkg::addr_t               redirect_pc
);

    rob_alloc_if #(.ROB_DEPTH(ROB_DEPTH)) alloc_bus ();
    rob_head_if  #(.ROB_DEPTH(ROB_DEPTH)) head_bus ();

    rob_alloc #(.ROB_DEPTH(ROB_DEPTH)) rob_alloc_inst (
        .clk              (clk),
        .rst              (rst),
        .alloc_req        (alloc_req),
        .alloc_is_store   (alloc_is_store),
        .alloc_pred_taken (alloc_pred_taken),
        .alloc_rd         (alloc_rd),
        .retire           (head_bus.retire),
        .flush            (head_bus.flush), // same-cycle flush, not the registered one
        .alloc_ok         (alloc_ok),
        .full             (full),
        .alloc_tag        (alloc_tag),
        .alloc            (alloc_bus)
    );

    rob_table #(.ROB_DEPTH(ROB_DEPTH)) rob_table_inst (
        .clk       (clk),
        .rst       (rst),
        .alloc     (alloc_bus),
        .ex_valid  (ex_valid),
        .ex_tag    (ex_tag),
        .ex_data   (ex_data),
        .ex_taken  (ex_taken),
        .ex_target (ex_target),
        .head      (head_bus)
    );

    rob_commit #(.ROB_DEPTH(ROB_DEPTH)) rob_commit_inst (
        .clk          (clk),
        .rst          (rst),
        .head         (head_bus),
        .rf_we        (rf_we),
        .rf_rd        (rf_rd),
        .rf_data      (rf_data),
        .rf_tag       (rf_tag),
        .store_commit (store_commit),
        .store_tag    (store_tag),
        .flush        (flush),
        .redirect_pc  (redirect_pc)
    );

endmodule

// ==== rob_top.f ====
design/rob_pkg.sv
design/rob_alloc_if.sv
design/rob_head_if.sv
design/rob_alloc.sv
design/rob_table.sv
design/rob_commit.sv
design/rob_top.sv
tests/tb_clock.sv
tests/rob_top_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the rob_top testbench with verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    -f rob_top.f --top-module rob_top_tb \
    -Mdir "$BUILD_DIR" -o rob_top_tb

"./$BUILD_DIR/rob_top_tb" | tee "$LOG"

if grep -q "^Result: PASSED$" "$LOG"; then
    echo "simulation ok, log in $LOG"
else
    echo "simulation reported failure, see $LOG"
    exit 1
fi

// ==== tests/rob_top_tb.sv ====
module rob_top_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rob_pkg::*;

    localparam int DEPTH       = 16;
    localparam int TAG_W       = $clog2(DEPTH);
    localparam int GRANT_WAIT  = 2 * DEPTH;
    localparam int DRAIN_WAIT  = 4 * DEPTH;
    localparam int N_OPS       = 3 * DEPTH + 16; // allocations plus completions
    localparam int WATCHDOG_NS = (N_OPS * 6 + 200) * 10;

    typedef logic [TAG_W-1:0] tag_t;
    typedef struct packed {
        tag_t      tag;
        reg_name_t rd;
        logic      is_store;
        logic      pred;
        logic      done;
        logic      mispredict;
        data_t     data;
        addr_t     target;
    } entry_t;

    logic clk, rst;
    logic alloc_req, alloc_is_store, alloc_pred_taken, alloc_ok, full;
    reg_name_t alloc_rd, rf_rd;
    tag_t alloc_tag, ex_tag, rf_tag, store_tag, tag;
    logic ex_valid, ex_taken, rf_we, store_commit, flush;
    data_t ex_data, rf_data;
    addr_t ex_target, redirect_pc;

    entry_t sb[$]; // pending entries in allocation order
    integer seed = 32'h55ef_9ac4;
    int errors, checks, tests_run, test_err_start, flush_count, waited;

    tb_clock clock_gen (.clk(clk), .rst(rst));

    rob_top #(.ROB_DEPTH(DEPTH)) rob_top_inst (
        .clk(clk), .rst(rst),
        .alloc_req(alloc_req), .alloc_rd(alloc_rd), .alloc_is_store(alloc_is_store),
        .alloc_pred_taken(alloc_pred_taken), .alloc_ok(alloc_ok), .alloc_tag(alloc_tag),
        .full(full), .ex_valid(ex_valid), .ex_tag(ex_tag), .ex_data(ex_data),
        .ex_taken(ex_taken), .ex_target(ex_target), .rf_we(rf_we), .rf_rd(rf_rd),
        .rf_data(rf_data), .rf_tag(rf_tag), .store_commit(store_commit),
        .store_tag(store_tag), .flush(flush), .redirect_pc(redirect_pc)
    );

    task automatic report_fail(input string what);
        errors++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic alloc_one(input reg_name_t rd, input logic st, input logic pt, output tag_t t);
        int n;
        entry_t e;
        n = 0;
        @(posedge clk);
        alloc_req        <= 1'b1;
        alloc_rd         <= rd;
        alloc_is_store   <= st;
        alloc_pred_taken <= pt;
        @(negedge clk);
        while (!alloc_ok && n < GRANT_WAIT) begin
            @(negedge clk);
            n++;
        end
        t = alloc_tag;
        if (!alloc_ok) report_fail("allocation request was never granted");
        else begin
            e = '0;
            e.tag = t;
            e.rd = rd;
            e.is_store = st;
            e.pred = pt;
            sb.push_back(e);
        end
        @(posedge clk); // grant edge
        alloc_req <= 1'b0;
    endtask

    task automatic complete(input tag_t t, input data_t d, input logic taken, input addr_t tgt);
        @(posedge clk);
        ex_valid  <= 1'b1;
        ex_tag    <= t;
        ex_data   <= d;
        ex_taken  <= taken;
        ex_target <= tgt;
        foreach (sb[i]) if (sb[i].tag == t && !sb[i].done) begin
            sb[i].done = 1'b1;
            sb[i].data = d;
            sb[i].target = tgt;
            sb[i].mispredict = sb[i].pred != taken;
        end
        @(posedge clk);
        ex_valid <= 1'b0;
    endtask

    task automatic complete_shuffled();
        tag_t order[$];
        tag_t t;
        int j;
        foreach (sb[i]) if (!sb[i].done) order.push_back(sb[i].tag);
        for (int i = order.size() - 1; i > 0; i--) begin
            j = int'($unsigned($random(seed)) % (i + 1));
            t = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        foreach (order[i]) complete(order[i], $random(seed), 1'b0, '0);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (sb.size() != 0 && n < DRAIN_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (sb.size() != 0) report_fail("buffer did not drain");
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %s finished with %0d errors", name, errors - test_err_start);
        test_err_start = errors;
    endtask

    // commit outputs checked against the oldest pending entry at the falling edge
    always @(negedge clk) begin
        entry_t e;
        if (!rst && (rf_we || store_commit)) begin
            if (sb.size() == 0) report_fail("commit output with no pending entry");
            else begin
                e = sb.pop_front();
                if (!e.done) report_fail("entry retired before it completed");
                check_val("rf_we", 32'(!e.is_store), 32'(rf_we));
                check_val("store_commit", 32'(e.is_store), 32'(store_commit));
                if (e.is_store) check_val("store_tag", 32'(e.tag), 32'(store_tag));
                else begin
                    check_val("rf_tag", 32'(e.tag), 32'(rf_tag));
                    check_val("rf_rd", 32'(e.rd), 32'(rf_rd));
                    check_val("rf_data", e.data, rf_data);
                end
                check_val("flush", 32'(e.mispredict), 32'(flush));
                if (e.mispredict) begin
                    check_val("redirect_pc", e.target, redirect_pc);
                    sb.delete(); // younger entries are gone
                    flush_count++;
                end
            end
        end else if (!rst && flush) report_fail("flush without a retiring entry");
    end

    no_grant_while_full: assert property (@(posedge clk) disable iff (rst) full |-> !alloc_ok)
        else report_fail("alloc_ok high while full");
    flush_retires_write: assert property (@(posedge clk) disable iff (rst) flush |-> rf_we)
        else report_fail("flush without its own register write");

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        alloc_req = 1'b0;
        alloc_rd = '0;
        alloc_is_store = 1'b0;
        alloc_pred_taken = 1'b0;
        ex_valid = 1'b0;
        ex_tag = '0;
        ex_data = '0;
        ex_taken = 1'b0;
        ex_target = '0;
        @(negedge clk);
        while (rst) @(negedge clk);
        check_val("alloc_ok", 32'd0, 32'(alloc_ok));
        check_val("full", 32'd0, 32'(full));
        check_val("rf_we", 32'd0, 32'(rf_we));
        check_val("store_commit", 32'd0, 32'(store_commit));
        check_val("flush", 32'd0, 32'(flush));

        for (int i = 0; i < DEPTH; i++) begin
            alloc_one(5'($random(seed)), 1'b0, NOT_TAKEN, tag);
            check_val("alloc_tag", 32'(i), 32'(tag));
        end
        @(negedge clk);
        check_val("full", 32'd1, 32'(full));
        end_test("tag_alloc");

        // request held while full and nothing done yet
        @(posedge clk);
        alloc_req <= 1'b1;
        alloc_rd  <= 5'd7;
        repeat (4) begin
            @(negedge clk);
            check_val("alloc_ok", 32'd0, 32'(alloc_ok));
        end
        complete(sb[0].tag, $random(seed), 1'b0, '0);
        alloc_one(5'd7, 1'b0, NOT_TAKEN, tag);
        check_val("alloc_tag", 32'((DEPTH - 1 + 1) % DEPTH), 32'(tag));
        end_test("backpressure");

        complete_shuffled();
        wait_drain();
        end_test("in_order_retire");

        for (int i = 0; i < 4; i++) alloc_one(5'($random(seed)), i[0], NOT_TAKEN, tag);
        complete_shuffled();
        wait_drain();
        end_test("store_retire");

        alloc_one(5'd3, 1'b0, NOT_TAKEN, tag); // branch predicted not taken
        alloc_one(5'd9, 1'b0, NOT_TAKEN, tag);
        alloc_one(5'd0, STORE, NOT_TAKEN, tag);
        complete(sb[2].tag, $random(seed), 1'b0, '0);
        complete(sb[1].tag, $random(seed), 1'b0, '0);
        complete(sb[0].tag, $random(seed), 1'b1, $random(seed));
        waited = 0;
        while (flush_count == 0 && waited < DRAIN_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (flush_count == 0) report_fail("mispredicted branch never flushed");
        repeat (2) @(negedge clk);
        check_val("full", 32'd0, 32'(full));
        alloc_one(5'd12, 1'b0, NOT_TAKEN, tag);
        check_val("alloc_tag", 32'd0, 32'(tag));
        complete_shuffled();
        wait_drain();
        end_test("mispredict_flush");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    // held for three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule
